/* rtl/aer_config.svh */
`ifndef AER_CONFIG_SVH
`define AER_CONFIG_SVH

// spike vector geometry
`define AER_WORD_WIDTH 16

// the word is split into lanes, one lane per tile column
`define AER_LANES 4
`define AER_LANE_WIDTH 4

// picture number wraps at this width
`define AER_PIC_NUM_WIDTH 10

`endif

/* rtl/aer_pkg.sv */
`default_nettype none

`include "aer_config.svh"

package aer_pkg;

    typedef logic [`AER_WORD_WIDTH-1:0] spike_word_t;

    // pending spikes of one lane
    typedef logic [`AER_LANE_WIDTH-1:0] lane_mask_t;

    // tile x/y, also lane number and bit offset inside a lane
    typedef logic [$clog2(`AER_LANE_WIDTH)-1:0] coord_t;

    typedef logic [`AER_PIC_NUM_WIDTH-1:0] pic_num_t;

    typedef struct packed {
        pic_num_t pic_num;
        coord_t   x;
        coord_t   y;
    } aer_event_t;

    typedef struct packed {
        logic   valid;
        coord_t offset;
    } lane_req_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_SCAN,
        LOAD_WRITEBACK
    } loader_state_e;

endpackage

`default_nettype wire

/* rtl/spike_word_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aer_config.svh"

module spike_word_loader import aer_pkg::*; (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              spike_valid,
    input  wire spike_word_t                 spike_word,
    input  wire                              timestep_clear,
    input  wire                              drained,
    output logic                             lane_load,
    output lane_mask_t [`AER_LANES-1:0]      lane_mask,
    output pic_num_t                         pic_num,
    output logic                             busy,
    output logic                             word_done
);

    loader_state_e state_q;
    loader_state_e state_d;
    spike_word_t   word_q;
    logic          accept;
    logic          in_idle;
    logic          in_writeback;

    assign in_idle      = (state_q == LOAD_IDLE);
    assign in_writeback = (state_q == LOAD_WRITEBACK);

    // strobes outside idle are dropped
    assign accept = in_idle && spike_valid;
    assign busy   = !in_idle;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOAD_IDLE: begin
                if (spike_valid) begin
                    state_d = LOAD_SCAN;
                end
            end
            LOAD_SCAN: begin
                // lanes still hold the old masks while the load pulse is out
                if (!lane_load && drained) begin
                    state_d = LOAD_WRITEBACK;
                end
            end
            LOAD_WRITEBACK: begin
                state_d = LOAD_IDLE;
            end
            default: begin
                state_d = LOAD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= LOAD_IDLE;
            lane_load <= 1'b0;
            word_done <= 1'b0;
        end else begin
            state_q   <= state_d;
            lane_load <= accept;
            word_done <= in_writeback;
        end
    end

    // one picture per accepted word, cleared between timesteps
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pic_num <= '0;
        end else if (in_writeback) begin
            pic_num <= pic_num + 1'b1;
        end else if (in_idle && timestep_clear) begin
            pic_num <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= spike_word;
        end
    end

    // lane i takes bits 4i..4i+3, so lane number is x and offset is y
    always_comb begin
        for (int i = 0; i < `AER_LANES; i++) begin
            lane_mask[i] = word_q[i*`AER_LANE_WIDTH +: `AER_LANE_WIDTH];
        end
    end

endmodule

`default_nettype wire

/* rtl/spike_lane_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aer_config.svh"

module spike_lane_encoder import aer_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             lane_load,
    input  wire lane_mask_t lane_mask,
    input  wire             lane_grant,
    output lane_req_t       lane_req
);

    lane_mask_t pending;
    coord_t     low_idx;

    // lowest pending bit goes out first
    always_comb begin
        low_idx = '0;
        for (int i = `AER_LANE_WIDTH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                low_idx = coord_t'(i);
            end
        end
    end

    assign lane_req = '{valid: |pending, offset: low_idx};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending <= '0;
        end else if (lane_load) begin
            pending <= lane_mask;
        end else if (lane_grant) begin
            // retire the bit that was just sent
            pending <= pending & ~(lane_mask_t'(1) << low_idx);
        end
    end

endmodule

`default_nettype wire

/* rtl/event_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aer_config.svh"

module event_serializer import aer_pkg::*; (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire lane_req_t [`AER_LANES-1:0]  lane_req,
    input  wire pic_num_t                    pic_num,
    output logic [`AER_LANES-1:0]            lane_grant,
    output logic                             event_valid,
    output aer_event_t                       event_out,
    output logic                             drained
);

    logic   any_req;
    coord_t sel_lane;
    coord_t sel_offset;

    // fixed priority, lane 0 wins
    // lower lanes hold lower bit indices, so order stays ascending
    always_comb begin
        any_req    = 1'b0;
        sel_lane   = '0;
        sel_offset = '0;
        for (int i = `AER_LANES - 1; i >= 0; i--) begin
            if (lane_req[i].valid) begin
                any_req    = 1'b1;
                sel_lane   = coord_t'(i);
                sel_offset = lane_req[i].offset;
            end
        end
    end

    always_comb begin
        lane_grant = '0;
        if (any_req) begin
            lane_grant[sel_lane] = 1'b1;
        end
    end

    assign drained = !any_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            event_valid <= 1'b0;
        end else begin
            event_valid <= any_req;
        end
    end

    // x from the lane, y from the bit inside it
    always_ff @(posedge clk) begin
        if (any_req) begin
            event_out <= '{pic_num: pic_num, x: sel_lane, y: sel_offset};
        end
    end

endmodule

`default_nettype wire

/* rtl/aer_encoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aer_config.svh"

module aer_encoder_top import aer_pkg::*; (
    input  wire              clk,
    input  wire              rstn,
    input  wire              spike_valid,
    input  wire spike_word_t spike_word,
    input  wire              timestep_clear,
    output logic             busy,
    output logic             event_valid,
    output aer_event_t       event_out,
    output logic             word_done
);

    logic                          lane_load;
    lane_mask_t [`AER_LANES-1:0]   lane_mask;
    pic_num_t                      pic_num;
    lane_req_t  [`AER_LANES-1:0]   lane_req;
    logic       [`AER_LANES-1:0]   lane_grant;
    logic                          drained;

    spike_word_loader u_loader (
        .clk            (clk),
        .rstn           (rstn),
        .spike_valid    (spike_valid),
        .spike_word     (spike_word),
        .timestep_clear (timestep_clear),
        .drained        (drained),
        .lane_load      (lane_load),
        .lane_mask      (lane_mask),
        .pic_num        (pic_num),
        .busy           (busy),
        .word_done      (word_done)
    );

    // one encoder per tile column
    for (genvar g = 0; g < `AER_LANES; g++) begin : g_lane
        spike_lane_encoder u_lane (
            .clk        (clk),
            .rstn       (rstn),
            .lane_load  (lane_load),
            .lane_mask  (lane_mask[g]),
            .lane_grant (lane_grant[g]),
            .lane_req   (lane_req[g])
        );
    end

    event_serializer u_serializer (
        .clk         (clk),
        .rstn        (rstn),
        .lane_req    (lane_req),
        .pic_num     (pic_num),
        .lane_grant  (lane_grant),
        .event_valid (event_valid),
        .event_out   (event_out),
        .drained     (drained)
    );

endmodule

`default_nettype wire

/* sim/aer_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module aer_clk_gen (
    output logic clk,
    output logic rstn
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 16;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // reset released between edges
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_aer_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aer_config.svh"

module tb_aer_encoder import aer_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_WORDS   = 40;

    typedef aer_event_t event_list_t[$];

    logic        clk;
    logic        rstn;
    logic        spike_valid;
    spike_word_t spike_word;
    logic        timestep_clear;
    logic        busy;
    logic        event_valid;
    aer_event_t  event_out;
    logic        word_done;

    // model state shared by stimulus and compare process
    aer_event_t  exp_q[$];
    pic_num_t    model_pic;
    pic_num_t    exp_count;
    pic_num_t    word_events;
    int          done_count;
    int          words_sent;
    int          seed;

    int          value_errors;
    int          other_errors;
    int          timeouts;

    aer_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    aer_encoder_top dut (
        .clk            (clk),
        .rstn           (rstn),
        .spike_valid    (spike_valid),
        .spike_word     (spike_word),
        .timestep_clear (timestep_clear),
        .busy           (busy),
        .event_valid    (event_valid),
        .event_out      (event_out),
        .word_done      (word_done)
    );

    // neuron n sits at column n/4, row n%4 of the tile
    function automatic event_list_t expected_events(input spike_word_t word,
                                                    input pic_num_t pic);
        event_list_t evs;
        aer_event_t  ev;
        for (int n = 0; n < `AER_WORD_WIDTH; n++) begin
            if (word[n]) begin
                ev.pic_num = pic;
                ev.x       = coord_t'(n / `AER_LANE_WIDTH);
                ev.y       = coord_t'(n % `AER_LANE_WIDTH);
                evs.push_back(ev);
            end
        end
        return evs;
    endfunction

    task automatic check_event(input aer_event_t got, input aer_event_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: event pic=%0d x=%0d y=%0d, expected pic=%0d x=%0d y=%0d",
                     $time, got.pic_num, got.x, got.y, exp.pic_num, exp.x, exp.y);
        end
    endtask

    task automatic check_count(input pic_num_t got, input pic_num_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: word gave %0d events, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: busy=%0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_word(input int target);
        int n;
        n = 0;
        while (done_count < target && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (done_count < target) begin
            timeouts++;
            $display("timeout: word_done did not arrive within %0d cycles", TIMEOUT_CYCLES);
        end
        #1;
    endtask

    // queue expectations and strobe the word for one cycle
    task automatic send_word(input spike_word_t w);
        event_list_t evs;
        evs = expected_events(w, model_pic);
        foreach (evs[i]) begin
            exp_q.push_back(evs[i]);
        end
        exp_count   = pic_num_t'(evs.size());
        spike_word  = w;
        spike_valid = 1'b1;
        @(posedge clk);
        #1;
        spike_valid = 1'b0;
        words_sent++;
    endtask

    task automatic run_word(input spike_word_t w);
        send_word(w);
        wait_for_word(words_sent);
        model_pic = model_pic + 1'b1;
    endtask

    task automatic pulse_clear();
        timestep_clear = 1'b1;
        @(posedge clk);
        #1;
        timestep_clear = 1'b0;
        model_pic = '0;
    endtask

    // sample mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rstn) begin
            // busy while a word is in flight, low again once word_done rises
            check_busy(busy, (words_sent > done_count) && !word_done);
            if (event_valid) begin
                word_events = word_events + 1'b1;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("unexpected event at %0t ns, nothing was pending", $time);
                end else begin
                    check_event(event_out, exp_q.pop_front());
                end
            end
            if (word_done) begin
                check_count(word_events, exp_count);
                // drop leftovers so the next word starts clean
                exp_q.delete();
                word_events = '0;
                done_count++;
            end
        end
    end

    initial begin
        spike_word_t w;

        seed           = 65;
        spike_valid    = 1'b0;
        spike_word     = '0;
        timestep_clear = 1'b0;
        model_pic      = '0;
        exp_count      = '0;
        word_events    = '0;
        done_count     = 0;
        words_sent     = 0;
        value_errors   = 0;
        other_errors   = 0;
        timeouts       = 0;

        wait_for_reset();
        if (busy !== 1'b0 || event_valid !== 1'b0 || word_done !== 1'b0) begin
            other_errors++;
            $display("outputs were not idle after reset");
        end

        // one spike at every position
        for (int n = 0; n < `AER_WORD_WIDTH; n++) begin
            run_word(spike_word_t'(1) << n);
        end

        // full and empty words
        run_word(16'hFFFF);
        run_word(16'h0000);

        // random words step the picture number once each
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            w = spike_word_t'($random(seed));
            run_word(w);
        end

        // clear while idle restarts the picture count
        pulse_clear();
        run_word(16'h8001);
        run_word(16'h0000);
        run_word(16'h0410);

        // strobe and clear during a scan are dropped
        send_word(16'h0F00);
        spike_word     = 16'hFFFF;
        spike_valid    = 1'b1;
        timestep_clear = 1'b1;
        @(posedge clk);
        #1;
        spike_valid    = 1'b0;
        timestep_clear = 1'b0;
        wait_for_word(words_sent);
        model_pic = model_pic + 1'b1;

        // next word shows the count was untouched
        run_word(16'h0002);
        if (done_count != words_sent) begin
            other_errors++;
            $display("saw %0d word_done pulses for %0d words", done_count, words_sent);
        end

        $display("errors: %0d value, %0d other, %0d timeout",
                 value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/aer_pkg.sv
rtl/spike_word_loader.sv
rtl/spike_lane_encoder.sv
rtl/event_serializer.sv
rtl/aer_encoder_top.sv
sim/aer_clk_gen.sv
sim/tb_aer_encoder.sv

/* Bender.yml */
package:
  name: aer_encoder

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/aer_pkg.sv
      - rtl/spike_word_loader.sv
      - rtl/spike_lane_encoder.sv
      - rtl/event_serializer.sv
      - rtl/aer_encoder_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/aer_clk_gen.sv
      - sim/tb_aer_encoder.sv
